// ==== source/state_lsu_pkg.sv ====
package state_lsu_pkg;

    localparam int COUNT_WIDTH = 10;

    typedef logic [31:0] word_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [7:0] mc_ins_t;
    typedef logic [4:0] pc_t;

    // Upper nibble of a microinstruction
    typedef enum logic [3:0] {
        OP_FINISH    = 4'b0000,
        OP_MUL       = 4'b0010,
        OP_ROUTE     = 4'b0100,
        OP_LOAD      = 4'b0101,
        OP_DMA_RADDR = 4'b1000,
        OP_DMA_RSIZE = 4'b1001,
        OP_DMA_WADDR = 4'b1100,
        OP_DMA_WSIZE = 4'b1101
    } opcode_e;

    typedef enum logic [3:0] {
        ROUTE_A    = 4'b0000,
        ROUTE_B    = 4'b0001,
        ROUTE_CNT  = 4'b1000,
        ROUTE_NONE = 4'b1111
    } route_e;

    typedef enum logic [3:0] {
        SIZE_1   = 4'b0000,
        SIZE_CNT = 4'b0001
    } size_e;

    typedef enum logic [3:0] {
        IDLE, FETCH, DECODE, DMA_ADDR, DMA_SIZE, DMA_WAIT
    } mc_state_e;

    // Procedure entry points in the microcode ROM
    localparam pc_t SAVE_ENTRY = 5'd0;
    localparam pc_t LOAD_ENTRY = 5'd14;

endpackage

// ==== source/dma_cmd_if.sv ====
`timescale 1ns/1ps

interface dma_cmd_if;
    import state_lsu_pkg::*;

    logic   cmd_valid;
    logic   cmd_ready;
    logic   cmd_write;
    logic   cmd_addr;
    count_t cmd_count;
    logic   idle;

    modport seq (
        output cmd_valid, cmd_write, cmd_addr, cmd_count,
        input  cmd_ready, idle
    );

    modport engine (
        input  cmd_valid, cmd_write, cmd_addr, cmd_count,
        output cmd_ready, idle
    );

endinterface

// ==== source/channel_router.sv ====
`timescale 1ns/1ps

module channel_router (
    input  state_lsu_pkg::route_e route,
    input  state_lsu_pkg::word_t  cnt_word,
    input  logic                  eng_wr_ready,
    input  logic                  eng_rd_valid,
    input  state_lsu_pkg::word_t  eng_rd_data,
    input  logic                  save_a_valid,
    input  state_lsu_pkg::word_t  save_a_data,
    input  logic                  save_b_valid,
    input  state_lsu_pkg::word_t  save_b_data,
    input  logic                  load_a_ready,
    input  logic                  load_b_ready,
    output logic                  eng_wr_valid,
    output state_lsu_pkg::word_t  eng_wr_data,
    output logic                  eng_rd_ready,
    output logic                  save_a_ready,
    output logic                  save_b_ready,
    output logic                  load_a_valid,
    output state_lsu_pkg::word_t  load_a_data,
    output logic                  load_b_valid,
    output state_lsu_pkg::word_t  load_b_data,
    output logic                  cnt_load_valid,
    output state_lsu_pkg::word_t  cnt_load_data
);
    import state_lsu_pkg::*;

    logic sel_a;
    logic sel_b;
    logic sel_cnt;

    assign sel_a   = route == ROUTE_A;
    assign sel_b   = route == ROUTE_B;
    assign sel_cnt = route == ROUTE_CNT;

    // Write side: count word or one queue into the engine
    assign eng_wr_valid = sel_cnt || (sel_a && save_a_valid) || (sel_b && save_b_valid);
    assign eng_wr_data  = sel_a ? save_a_data : (sel_b ? save_b_data : cnt_word);
    assign save_a_ready = sel_a && eng_wr_ready;
    assign save_b_ready = sel_b && eng_wr_ready;

    // Read side: engine output to the count path or one restore stream
    assign load_a_valid   = sel_a && eng_rd_valid;
    assign load_b_valid   = sel_b && eng_rd_valid;
    assign cnt_load_valid = sel_cnt && eng_rd_valid;
    assign load_a_data    = eng_rd_data;
    assign load_b_data    = eng_rd_data;
    assign cnt_load_data  = eng_rd_data;

    // Count path never stalls
    assign eng_rd_ready = sel_cnt || (sel_a && load_a_ready) || (sel_b && load_b_ready);

endmodule

// ==== source/wb_dma_engine.sv ====
`timescale 1ns/1ps

module wb_dma_engine #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_valid,
    input  state_lsu_pkg::word_t  wr_data,
    output logic                  wr_ready,
    output logic                  rd_valid,
    output state_lsu_pkg::word_t  rd_data,
    input  logic                  rd_ready,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [ADDR_WIDTH-1:0] wb_adr,
    output state_lsu_pkg::word_t  wb_dat_w,
    input  state_lsu_pkg::word_t  wb_dat_r,
    input  logic                  wb_ack,
    dma_cmd_if.engine             dma
);
    import state_lsu_pkg::*;

    typedef enum logic [2:0] {
        E_IDLE, E_WR_TAKE, E_WR_BUS, E_RD_BUS, E_RD_HOLD
    } eng_state_e;

    eng_state_e            state;
    logic [ADDR_WIDTH-1:0] adr_q;
    count_t                rem_q;
    word_t                 buf_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= E_IDLE;
            adr_q <= '0;
            rem_q <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (dma.cmd_valid && dma.cmd_addr) begin
                        adr_q <= '0;
                    end else if (dma.cmd_valid && dma.cmd_count != '0) begin
                        rem_q <= dma.cmd_count;
                        state <= dma.cmd_write ? E_WR_TAKE : E_RD_BUS;
                    end
                end
                E_WR_TAKE: begin
                    if (wr_valid)
                        state <= E_WR_BUS;
                end
                E_WR_BUS: begin
                    if (wb_ack) begin
                        adr_q <= adr_q + 1'b1;
                        rem_q <= rem_q - 1'b1;
                        state <= (rem_q == count_t'(1)) ? E_IDLE : E_WR_TAKE;
                    end
                end
                E_RD_BUS: begin
                    if (wb_ack) begin
                        adr_q <= adr_q + 1'b1;
                        rem_q <= rem_q - 1'b1;
                        state <= E_RD_HOLD;
                    end
                end
                E_RD_HOLD: begin
                    // Next bus cycle only after the word is taken
                    if (rd_ready)
                        state <= (rem_q == '0) ? E_IDLE : E_RD_BUS;
                end
                default: begin
                    state <= E_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_WR_TAKE && wr_valid)
            buf_q <= wr_data;
        else if (state == E_RD_BUS && wb_ack)
            buf_q <= wb_dat_r;
    end

    assign dma.cmd_ready = state == E_IDLE;
    assign dma.idle      = state == E_IDLE;

    assign wr_ready = state == E_WR_TAKE;
    assign rd_valid = state == E_RD_HOLD;
    assign rd_data  = buf_q;

    assign wb_cyc   = (state == E_WR_BUS) || (state == E_RD_BUS);
    assign wb_stb   = wb_cyc;
    assign wb_we    = state == E_WR_BUS;
    assign wb_adr   = adr_q;
    assign wb_dat_w = buf_q;

    // A bus cycle always has a word left to move
    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> (wb_cyc && rem_q != '0));

    // Classic cycle held with stable request until acknowledged
    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=>
            (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)));

endmodule

// ==== source/mc_sequencer.sv ====
`timescale 1ns/1ps

module mc_sequencer #(
    parameter int A_ITEM_WORDS = 2,
    parameter int B_ITEM_WORDS = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  save,
    input  logic                  load,
    input  state_lsu_pkg::count_t a_count,
    input  state_lsu_pkg::count_t b_count,
    input  logic                  cnt_load_valid,
    input  state_lsu_pkg::word_t  cnt_load_data,
    output logic                  complete,
    output state_lsu_pkg::route_e route,
    output state_lsu_pkg::word_t  cnt_word,
    dma_cmd_if.seq                dma
);
    import state_lsu_pkg::*;

    localparam logic [3:0] A_SIZE = 4'(A_ITEM_WORDS);
    localparam logic [3:0] B_SIZE = 4'(B_ITEM_WORDS);

    mc_state_e state;
    mc_state_e state_next;
    pc_t       pc;
    mc_ins_t   ins;
    mc_ins_t   rom_data;
    count_t    cnt;
    route_e    route_q;
    opcode_e   op;
    logic [3:0] arg;

    assign op  = opcode_e'(ins[7:4]);
    assign arg = ins[3:0];

    // Save occupies 0..13, load starts at LOAD_ENTRY
    always_comb begin
        case (pc)
            5'd0:    rom_data = {OP_DMA_WADDR, 4'h0};
            5'd1:    rom_data = {OP_LOAD,      ROUTE_A};
            5'd2:    rom_data = {OP_ROUTE,     ROUTE_CNT};
            5'd3:    rom_data = {OP_DMA_WSIZE, SIZE_1};
            5'd4:    rom_data = {OP_MUL,       A_SIZE};
            5'd5:    rom_data = {OP_ROUTE,     ROUTE_A};
            5'd6:    rom_data = {OP_DMA_WSIZE, SIZE_CNT};
            5'd7:    rom_data = {OP_LOAD,      ROUTE_B};
            5'd8:    rom_data = {OP_ROUTE,     ROUTE_CNT};
            5'd9:    rom_data = {OP_DMA_WSIZE, SIZE_1};
            5'd10:   rom_data = {OP_MUL,       B_SIZE};
            5'd11:   rom_data = {OP_ROUTE,     ROUTE_B};
            5'd12:   rom_data = {OP_DMA_WSIZE, SIZE_CNT};
            5'd13:   rom_data = {OP_FINISH,    4'h0};
            5'd14:   rom_data = {OP_DMA_RADDR, 4'h0};
            5'd15:   rom_data = {OP_ROUTE,     ROUTE_CNT};
            5'd16:   rom_data = {OP_DMA_RSIZE, SIZE_1};
            5'd17:   rom_data = {OP_MUL,       A_SIZE};
            5'd18:   rom_data = {OP_ROUTE,     ROUTE_A};
            5'd19:   rom_data = {OP_DMA_RSIZE, SIZE_CNT};
            5'd20:   rom_data = {OP_ROUTE,     ROUTE_CNT};
            5'd21:   rom_data = {OP_DMA_RSIZE, SIZE_1};
            5'd22:   rom_data = {OP_MUL,       B_SIZE};
            5'd23:   rom_data = {OP_ROUTE,     ROUTE_B};
            5'd24:   rom_data = {OP_DMA_RSIZE, SIZE_CNT};
            default: rom_data = {OP_FINISH,    4'h0};
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (save || load)
                    state_next = FETCH;
            end
            FETCH: begin
                state_next = DECODE;
            end
            DECODE: begin
                case (op)
                    OP_MUL, OP_ROUTE, OP_LOAD:
                        state_next = FETCH;
                    OP_DMA_RADDR, OP_DMA_WADDR:
                        state_next = DMA_ADDR;
                    OP_DMA_RSIZE, OP_DMA_WSIZE:
                        state_next = DMA_SIZE;
                    default:
                        state_next = IDLE;
                endcase
            end
            DMA_ADDR: begin
                if (dma.cmd_ready)
                    state_next = FETCH;
            end
            DMA_SIZE: begin
                if (dma.cmd_ready)
                    state_next = DMA_WAIT;
            end
            DMA_WAIT: begin
                if (dma.idle)
                    state_next = FETCH;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            pc      <= SAVE_ENTRY;
            route_q <= ROUTE_NONE;
        end else begin
            state <= state_next;
            if (state == IDLE)
                pc <= load ? LOAD_ENTRY : SAVE_ENTRY;
            else if (state == FETCH)
                pc <= pc + pc_t'(1);
            if (state == DECODE && op == OP_ROUTE)
                route_q <= route_e'(arg);
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH)
            ins <= rom_data;
    end

    // Count comes from the queue inputs on save, from memory on load
    always_ff @(posedge clk) begin
        if (state == DECODE && op == OP_MUL) begin
            cnt <= count_t'(cnt * arg);
        end else if (state == DECODE && op == OP_LOAD) begin
            case (route_e'(arg))
                ROUTE_A: cnt <= a_count;
                ROUTE_B: cnt <= b_count;
                default: cnt <= cnt;
            endcase
        end else if (cnt_load_valid) begin
            cnt <= cnt_load_data[COUNT_WIDTH-1:0];
        end
    end

    assign dma.cmd_valid = (state == DMA_ADDR) || (state == DMA_SIZE);
    assign dma.cmd_addr  = state == DMA_ADDR;
    assign dma.cmd_write = (op == OP_DMA_WADDR) || (op == OP_DMA_WSIZE);
    assign dma.cmd_count = (size_e'(arg) == SIZE_CNT) ? cnt : count_t'(1);

    assign route    = (state == DMA_WAIT) ? route_q : ROUTE_NONE;
    assign cnt_word = word_t'(cnt);
    assign complete = (state == DECODE) && (op == OP_FINISH);

    // Between procedures the engine has drained and no command is pending
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> (!dma.cmd_valid && dma.idle));

endmodule

// ==== source/state_lsu_top.sv ====
`timescale 1ns/1ps

module state_lsu_top #(
    parameter int A_ITEM_WORDS = 2,
    parameter int B_ITEM_WORDS = 1,
    parameter int ADDR_WIDTH   = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   save,
    input  logic                   load,
    output logic                   complete,

    input  logic                   save_a_valid,
    input  state_lsu_pkg::word_t   save_a_data,
    output logic                   save_a_ready,
    input  logic                   save_b_valid,
    input  state_lsu_pkg::word_t   save_b_data,
    output logic                   save_b_ready,

    input  state_lsu_pkg::count_t  a_count,
    input  state_lsu_pkg::count_t  b_count,

    output logic                   load_a_valid,
    output state_lsu_pkg::word_t   load_a_data,
    input  logic                   load_a_ready,
    output logic                   load_b_valid,
    output state_lsu_pkg::word_t   load_b_data,
    input  logic                   load_b_ready,

    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [ADDR_WIDTH-1:0]  wb_adr,
    output state_lsu_pkg::word_t   wb_dat_w,
    input  state_lsu_pkg::word_t   wb_dat_r,
    input  logic                   wb_ack
);
    import state_lsu_pkg::*;

    route_e route;
    word_t  cnt_word;
    logic   cnt_load_valid;
    word_t  cnt_load_data;

    logic   eng_wr_valid;
    logic   eng_wr_ready;
    word_t  eng_wr_data;
    logic   eng_rd_valid;
    logic   eng_rd_ready;
    word_t  eng_rd_data;

    dma_cmd_if dma ();

    mc_sequencer #(
        .A_ITEM_WORDS   (A_ITEM_WORDS),
        .B_ITEM_WORDS   (B_ITEM_WORDS)
    ) u_seq (
        .clk            (clk),
        .rst            (rst),
        .save           (save),
        .load           (load),
        .a_count        (a_count),
        .b_count        (b_count),
        .cnt_load_valid (cnt_load_valid),
        .cnt_load_data  (cnt_load_data),
        .complete       (complete),
        .route          (route),
        .cnt_word       (cnt_word),
        .dma            (dma.seq)
    );

    wb_dma_engine #(
        .ADDR_WIDTH     (ADDR_WIDTH)
    ) u_engine (
        .clk            (clk),
        .rst            (rst),
        .wr_valid       (eng_wr_valid),
        .wr_data        (eng_wr_data),
        .wr_ready       (eng_wr_ready),
        .rd_valid       (eng_rd_valid),
        .rd_data        (eng_rd_data),
        .rd_ready       (eng_rd_ready),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .dma            (dma.engine)
    );

    channel_router u_router (
        .route          (route),
        .cnt_word       (cnt_word),
        .eng_wr_ready   (eng_wr_ready),
        .eng_rd_valid   (eng_rd_valid),
        .eng_rd_data    (eng_rd_data),
        .save_a_valid   (save_a_valid),
        .save_a_data    (save_a_data),
        .save_b_valid   (save_b_valid),
        .save_b_data    (save_b_data),
        .load_a_ready   (load_a_ready),
        .load_b_ready   (load_b_ready),
        .eng_wr_valid   (eng_wr_valid),
        .eng_wr_data    (eng_wr_data),
        .eng_rd_ready   (eng_rd_ready),
        .save_a_ready   (save_a_ready),
        .save_b_ready   (save_b_ready),
        .load_a_valid   (load_a_valid),
        .load_a_data    (load_a_data),
        .load_b_valid   (load_b_valid),
        .load_b_data    (load_b_data),
        .cnt_load_valid (cnt_load_valid),
        .cnt_load_data  (cnt_load_data)
    );

endmodule

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 save,
    input  logic                 load,
    input  logic                 complete,
    input  logic                 save_a_valid,
    input  logic                 save_a_ready,
    input  logic                 save_b_valid,
    input  logic                 save_b_ready,
    input  logic                 load_a_valid,
    input  logic                 load_a_ready,
    input  state_lsu_pkg::word_t load_a_data,
    input  logic                 load_b_valid,
    input  logic                 load_b_ready,
    input  state_lsu_pkg::word_t load_b_data,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [15:0]          wb_adr,
    input  state_lsu_pkg::word_t wb_dat_w,
    input  logic                 wb_ack,
    input  state_lsu_pkg::word_t exp_img [0:255],
    input  int                   a_num,
    input  int                   b_num,
    output int                   err_count = 0,
    output int                   chk_count = 0
);
    import state_lsu_pkg::*;

    logic        active = 1'b0;
    logic        saving = 1'b0;
    logic        rst_d = 1'b0;
    logic        wait_ack = 1'b0;
    logic [15:0] prev_adr;
    logic        prev_we;
    word_t       prev_dat;
    int          wr_idx = 0;
    int          acc_a = 0;
    int          acc_b = 0;
    int          ld_a = 0;
    int          ld_b = 0;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        chk_count++;
        if (got !== expected) begin
            err_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report(input string msg);
        chk_count++;
        err_count++;
        $display("At %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        // Outputs right after reset
        if (rst_d && !rst) begin
            check_value("idle outputs after reset",
                {complete, wb_cyc, wb_stb, save_a_ready, save_b_ready,
                 load_a_valid, load_b_valid}, '0);
        end
        if (!rst) begin
            if (wait_ack) begin
                if (!wb_stb)
                    report("bus cycle dropped before ack");
                check_value("held wb_adr", wb_adr, prev_adr);
                check_value("held wb_we", wb_we, prev_we);
                check_value("held wb_dat_w", wb_dat_w, prev_dat);
            end
            if (save || load) begin
                active = 1'b1;
                saving = save;
                wr_idx = 0;
                acc_a = 0;
                acc_b = 0;
                ld_a = 0;
                ld_b = 0;
            end
            if (wb_cyc && wb_stb && wb_ack && wb_we) begin
                if (!saving || wr_idx >= 2 + a_num + b_num) begin
                    report("bus write outside the saved layout");
                end else begin
                    check_value("write address", wb_adr, wr_idx);
                    check_value("write data", wb_dat_w, exp_img[wr_idx]);
                    wr_idx++;
                end
            end
            if (save_a_valid && save_a_ready)
                acc_a++;
            if (save_b_valid && save_b_ready)
                acc_b++;
            if (load_a_valid && load_a_ready) begin
                if (ld_a >= a_num)
                    report("extra word on restore stream A");
                else
                    check_value("restored A word", load_a_data, exp_img[1 + ld_a]);
                ld_a++;
            end
            if (load_b_valid && load_b_ready) begin
                if (ld_b >= b_num)
                    report("extra word on restore stream B");
                else
                    check_value("restored B word", load_b_data, exp_img[2 + a_num + ld_b]);
                ld_b++;
            end
            if (complete) begin
                if (!active) begin
                    report("complete pulsed with no procedure running");
                end else if (saving) begin
                    check_value("words written", wr_idx, 2 + a_num + b_num);
                    check_value("A queue words taken", acc_a, a_num);
                    check_value("B queue words taken", acc_b, b_num);
                end else begin
                    check_value("A queue words taken on load", acc_a, 0);
                    check_value("B queue words taken on load", acc_b, 0);
                    check_value("A words restored", ld_a, a_num);
                    check_value("B words restored", ld_b, b_num);
                end
                active = 1'b0;
            end
        end
        wait_ack = !rst && wb_stb && !wb_ack;
        prev_adr = wb_adr;
        prev_we = wb_we;
        prev_dat = wb_dat_w;
        rst_d = rst;
    end

endmodule

// ==== tests/tb_state_lsu.sv ====
`timescale 1ns/1ps

module tb_state_lsu;
    import state_lsu_pkg::*;

    localparam int A_ITEM = 2;
    localparam int NUM_ROWS = 6;
    localparam int ROW_A [NUM_ROWS] = '{3, 0, 5, 2, 0, 7};
    localparam int ROW_B [NUM_ROWS] = '{4, 0, 2, 0, 3, 5};
    localparam int ROW_DELAY [NUM_ROWS] = '{0, 0, 3, 1, 2, 0};
    localparam logic [3:0] ROW_RDY [NUM_ROWS] =
        '{4'b1111, 4'b1111, 4'b0101, 4'b0011, 4'b1001, 4'b0110};

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        save = 1'b0;
    logic        load = 1'b0;
    logic        complete;
    logic        save_a_valid = 1'b0;
    word_t       save_a_data = '0;
    logic        save_a_ready;
    logic        save_b_valid = 1'b0;
    word_t       save_b_data = '0;
    logic        save_b_ready;
    count_t      a_count = '0;
    count_t      b_count = '0;
    logic        load_a_valid;
    word_t       load_a_data;
    logic        load_a_ready = 1'b0;
    logic        load_b_valid;
    word_t       load_b_data;
    logic        load_b_ready = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r = '0;
    logic        wb_ack = 1'b0;

    word_t       mem [0:255];
    word_t       exp_img [0:255];
    word_t       src_a [0:255];
    word_t       src_b [0:255];
    int          a_num = 0;
    int          b_num = 0;
    int          a_idx = 0;
    int          b_idx = 0;
    int          ack_delay = 0;
    int          ack_wait = 0;
    int          rdy_phase = 0;
    logic [3:0]  rdy_pat = 4'b1111;
    logic [31:0] rng = 32'd37;
    int          err_count;
    int          chk_count;

    state_lsu_top #(.A_ITEM_WORDS(A_ITEM), .B_ITEM_WORDS(1), .ADDR_WIDTH(16)) UUT (
        .clk(clk), .rst(rst), .save(save), .load(load), .complete(complete),
        .save_a_valid(save_a_valid), .save_a_data(save_a_data), .save_a_ready(save_a_ready),
        .save_b_valid(save_b_valid), .save_b_data(save_b_data), .save_b_ready(save_b_ready),
        .a_count(a_count), .b_count(b_count),
        .load_a_valid(load_a_valid), .load_a_data(load_a_data), .load_a_ready(load_a_ready),
        .load_b_valid(load_b_valid), .load_b_data(load_b_data), .load_b_ready(load_b_ready),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    tb_checker chk (
        .clk(clk), .rst(rst), .save(save), .load(load), .complete(complete),
        .save_a_valid(save_a_valid), .save_a_ready(save_a_ready),
        .save_b_valid(save_b_valid), .save_b_ready(save_b_ready),
        .load_a_valid(load_a_valid), .load_a_ready(load_a_ready), .load_a_data(load_a_data),
        .load_b_valid(load_b_valid), .load_b_ready(load_b_ready), .load_b_data(load_b_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .exp_img(exp_img),
        .a_num(a_num), .b_num(b_num), .err_count(err_count), .chk_count(chk_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        forever #20 clk = ~clk;
    end

    // Memory fill, memory writes and queue source progress
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++)
                mem[i] <= {16'hc0de, ~i[7:0], i[7:0]};
        end else if (wb_cyc && wb_stb && wb_ack && wb_we) begin
            mem[wb_adr[7:0]] <= wb_dat_w;
        end
        if (save) begin
            a_idx <= 0;
            b_idx <= 0;
        end else begin
            if (save_a_valid && save_a_ready)
                a_idx <= a_idx + 1;
            if (save_b_valid && save_b_ready)
                b_idx <= b_idx + 1;
        end
    end

    always @(negedge clk) begin
        // Queue sources never run dry
        save_a_valid = 1'b1;
        save_a_data = src_a[a_idx[7:0]];
        save_b_valid = 1'b1;
        save_b_data = src_b[b_idx[7:0]];
        rdy_phase++;
        load_a_ready = rdy_pat[rdy_phase % 4];
        load_b_ready = rdy_pat[(rdy_phase + 1) % 4];
        if (wb_ack) begin
            wb_ack = 1'b0;
            ack_wait = 0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait >= ack_delay) begin
                wb_ack = 1'b1;
                wb_dat_r = mem[wb_adr[7:0]];
            end else begin
                ack_wait++;
            end
        end
    end

    task automatic run_procedure(input logic is_save);
        @(negedge clk);
        save = is_save;
        load = !is_save;
        @(negedge clk);
        save = 1'b0;
        load = 1'b0;
        do @(posedge clk); while (!complete);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            a_count = count_t'(ROW_A[r]);
            b_count = count_t'(ROW_B[r]);
            ack_delay = ROW_DELAY[r];
            rdy_pat = ROW_RDY[r];
            // Expected host layout: A count, A words, B count, B words
            exp_img[0] = word_t'(ROW_A[r]);
            for (int i = 0; i < A_ITEM * ROW_A[r]; i++) begin
                rng = xorshift(rng);
                src_a[i] = rng;
                exp_img[1 + i] = rng;
            end
            exp_img[1 + A_ITEM * ROW_A[r]] = word_t'(ROW_B[r]);
            for (int i = 0; i < ROW_B[r]; i++) begin
                rng = xorshift(rng);
                src_b[i] = rng;
                exp_img[2 + A_ITEM * ROW_A[r] + i] = rng;
            end
            a_num = A_ITEM * ROW_A[r];
            b_num = ROW_B[r];
            run_procedure(1'b1);
            run_procedure(1'b0);
        end
        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0 && chk_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget of 40 cycles per moved word, saves and loads alike
    initial begin
        int words;
        words = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            words += 2 * (A_ITEM * ROW_A[r] + ROW_B[r] + 2);
        #((words * 40 + 200) * 40);
        $display("Timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/state_lsu_pkg.sv
source/dma_cmd_if.sv
source/channel_router.sv
source/wb_dma_engine.sv
source/mc_sequencer.sv
source/state_lsu_top.sv
tests/tb_checker.sv
tests/tb_state_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_state_lsu -f vlog.f \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation run returned an error, see sim.log"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
